/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_debug_core
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  := *** TEST PASSED ***

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(BUILD_DIR)

/* block_memory.sv */
`default_nettype none

module block_memory
    import debug_pkg::*;
#(
    parameter int MEM_WIDTH = 32,
    parameter int MEM_DEPTH = 256
) (
    input  wire                         clk,
    input  wire                         rst_i,
    input  wire bus_addr_t              req_addr_i,
    input  wire bus_data_t              req_data_i,
    input  wire                         req_write_i,
    input  wire                         req_valid_i,
    output bus_data_t                   rsp_data_o,
    output logic                        rsp_valid_o,
    input  wire [$clog2(MEM_DEPTH)-1:0] user_addr_i,
    input  wire [MEM_WIDTH-1:0]         user_wdata_i,
    input  wire                         user_we_i,
    output logic [MEM_WIDTH-1:0]        user_rdata_o
);

    localparam int N_BANKS  = (MEM_WIDTH + BANK_WIDTH - 1) / BANK_WIDTH;
    localparam int ADDR_W   = $clog2(MEM_DEPTH);
    localparam int TOP_ADDR = MEM_DEPTH * N_BANKS;

    logic [ADDR_W-1:0]               a_addr;
    bus_data_t                       a_wdata;
    logic [N_BANKS-1:0]              a_we;
    bus_data_t                       a_rdata [N_BANKS];
    logic [N_BANKS*BANK_WIDTH-1:0]   user_wdata_pad;
    logic [N_BANKS*BANK_WIDTH-1:0]   user_rdata_all;
    bus_addr_t                       pipe_addr [3];
    logic [2:0]                      pipe_valid;
    logic [2:0]                      pipe_read;

    // a_addr and a_wdata are shared, the write enable picks the bank
    always_ff @(posedge clk) begin
        if (rst_i) begin
            a_we        <= '0;
            pipe_valid  <= '0;
            rsp_valid_o <= 1'b0;
        end else begin
            a_we <= '0;
            if (req_valid_i && (req_addr_i < TOP_ADDR)) begin
                a_we[req_addr_i % N_BANKS] <= req_write_i;
            end
            pipe_valid  <= {pipe_valid[1:0], req_valid_i};
            rsp_valid_o <= pipe_valid[2] && pipe_read[2];
        end
    end

    always_ff @(posedge clk) begin
        a_addr  <= ADDR_W'(req_addr_i / N_BANKS);
        a_wdata <= req_data_i;
        pipe_addr[0] <= req_addr_i;
        pipe_addr[1] <= pipe_addr[0];
        pipe_addr[2] <= pipe_addr[1];
        pipe_read    <= {pipe_read[1:0], !req_write_i};
        // ram output lines up with the third pipeline stage
        if (pipe_addr[2] < TOP_ADDR) begin
            rsp_data_o <= a_rdata[pipe_addr[2] % N_BANKS];
        end else begin
            rsp_data_o <= '0;
        end
    end

    assign user_wdata_pad = (N_BANKS * BANK_WIDTH)'(user_wdata_i);
    assign user_rdata_o   = user_rdata_all[MEM_WIDTH-1:0];

    for (genvar i = 0; i < N_BANKS; i++) begin : g_bank
        dual_port_ram #(
            .MEM_DEPTH(MEM_DEPTH)
        ) u_ram (
            .clk       (clk),
            .a_addr_i  (a_addr),
            .a_wdata_i (a_wdata),
            .a_we_i    (a_we[i]),
            .a_rdata_o (a_rdata[i]),
            .b_addr_i  (user_addr_i),
            .b_wdata_i (user_wdata_pad[i*BANK_WIDTH +: BANK_WIDTH]),
            .b_we_i    (user_we_i),
            .b_rdata_o (user_rdata_all[i*BANK_WIDTH +: BANK_WIDTH])
        );
    end

endmodule

`default_nettype wire

/* bridge_rx.sv */
`default_nettype none

module bridge_rx
    import debug_pkg::*;
(
    input  wire        clk,
    input  wire        rst_i,
    input  wire byte_t rx_byte_i,
    input  wire        rx_valid_i,
    output bus_addr_t  req_addr_o,
    output bus_data_t  req_data_o,
    output logic       req_write_o,
    output logic       req_valid_o
);

    parse_state_e state;
    logic [3:0]   char_cnt;
    logic [31:0]  nibbles;
    logic [3:0]   last_pos;
    logic         is_term;

    // position of the terminator after the hex digits
    assign last_pos = (state == PARSE_WRITE) ? 4'd8 : 4'd4;
    assign is_term  = (rx_byte_i == CHAR_CR) || (rx_byte_i == CHAR_LF);

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state       <= PARSE_IDLE;
            char_cnt    <= '0;
            req_valid_o <= 1'b0;
        end else begin
            req_valid_o <= 1'b0;
            if (rx_valid_i) begin
                if (state == PARSE_IDLE) begin
                    // anything but a command letter is dropped here
                    if (rx_byte_i == CHAR_R) begin
                        state <= PARSE_READ;
                    end else if (rx_byte_i == CHAR_W) begin
                        state <= PARSE_WRITE;
                    end
                end else if (char_cnt == last_pos) begin
                    state       <= PARSE_IDLE;
                    char_cnt    <= '0;
                    req_valid_o <= is_term;
                end else if (is_hex_char(rx_byte_i)) begin
                    char_cnt <= char_cnt + 4'd1;
                end else begin
                    state    <= PARSE_IDLE;
                    char_cnt <= '0;
                end
            end
        end
    end

    // hex digits shift in most significant first
    always_ff @(posedge clk) begin
        if (rx_valid_i && (state != PARSE_IDLE) && (char_cnt != last_pos)) begin
            nibbles <= {nibbles[27:0], hex_to_nibble(rx_byte_i)};
        end
    end

    always_ff @(posedge clk) begin
        if (rx_valid_i && (state != PARSE_IDLE) && (char_cnt == last_pos)) begin
            req_write_o <= (state == PARSE_WRITE);
            if (state == PARSE_WRITE) begin
                req_addr_o <= nibbles[31:16];
                req_data_o <= nibbles[15:0];
            end else begin
                req_addr_o <= nibbles[15:0];
                req_data_o <= '0;
            end
        end
    end

endmodule

`default_nettype wire

/* bridge_tx.sv */
`default_nettype none

module bridge_tx
    import debug_pkg::*;
(
    input  wire            clk,
    input  wire            rst_i,
    input  wire bus_data_t rsp_data_i,
    input  wire            rsp_valid_i,
    input  wire            tx_done_i,
    output byte_t          tx_byte_o,
    output logic           tx_start_o
);

    localparam logic [2:0] LAST_BYTE = 3'd6;

    logic      busy;
    logic [2:0] byte_cnt;
    bus_data_t rsp_q;

    assign tx_start_o = busy;

    // byte_cnt counts bytes already handed to the uart
    always_ff @(posedge clk) begin
        if (rst_i) begin
            busy     <= 1'b0;
            byte_cnt <= '0;
        end else if (!busy) begin
            busy <= rsp_valid_i;
        end else if (tx_done_i) begin
            if (byte_cnt == LAST_BYTE) begin
                byte_cnt <= '0;
                busy     <= rsp_valid_i;
            end else begin
                byte_cnt <= byte_cnt + 3'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rsp_valid_i && (!busy || (tx_done_i && (byte_cnt == LAST_BYTE)))) begin
            rsp_q <= rsp_data_i;
        end
    end

    always_comb begin
        case (byte_cnt)
            3'd0:    tx_byte_o = CHAR_D;
            3'd1:    tx_byte_o = nibble_to_hex(rsp_q[15:12]);
            3'd2:    tx_byte_o = nibble_to_hex(rsp_q[11:8]);
            3'd3:    tx_byte_o = nibble_to_hex(rsp_q[7:4]);
            3'd4:    tx_byte_o = nibble_to_hex(rsp_q[3:0]);
            3'd5:    tx_byte_o = CHAR_CR;
            default: tx_byte_o = CHAR_LF;
        endcase
    end

endmodule

`default_nettype wire

/* debug_core.sv */
`default_nettype none

module debug_core
    import debug_pkg::*;
#(
    parameter int CLOCKS_PER_BAUD = 8,
    parameter int MEM_WIDTH       = 32,
    parameter int MEM_DEPTH       = 256
) (
    input  wire                         clk,
    input  wire                         rst_i,
    input  wire                         rx_i,
    output logic                        tx_o,
    input  wire [$clog2(MEM_DEPTH)-1:0] user_addr_i,
    input  wire [MEM_WIDTH-1:0]         user_wdata_i,
    input  wire                         user_we_i,
    output logic [MEM_WIDTH-1:0]        user_rdata_o
);

    byte_t     rx_byte;
    logic      rx_valid;
    bus_addr_t req_addr;
    bus_data_t req_data;
    logic      req_write;
    logic      req_valid;
    bus_data_t rsp_data;
    logic      rsp_valid;
    byte_t     tx_byte;
    logic      tx_start;
    logic      tx_done;

    uart_rx #(
        .CLOCKS_PER_BAUD(CLOCKS_PER_BAUD)
    ) u_uart_rx (
        .clk        (clk),
        .rst_i      (rst_i),
        .rx_i       (rx_i),
        .rx_byte_o  (rx_byte),
        .rx_valid_o (rx_valid)
    );

    bridge_rx u_bridge_rx (
        .clk         (clk),
        .rst_i       (rst_i),
        .rx_byte_i   (rx_byte),
        .rx_valid_i  (rx_valid),
        .req_addr_o  (req_addr),
        .req_data_o  (req_data),
        .req_write_o (req_write),
        .req_valid_o (req_valid)
    );

    block_memory #(
        .MEM_WIDTH(MEM_WIDTH),
        .MEM_DEPTH(MEM_DEPTH)
    ) u_block_memory (
        .clk          (clk),
        .rst_i        (rst_i),
        .req_addr_i   (req_addr),
        .req_data_i   (req_data),
        .req_write_i  (req_write),
        .req_valid_i  (req_valid),
        .rsp_data_o   (rsp_data),
        .rsp_valid_o  (rsp_valid),
        .user_addr_i  (user_addr_i),
        .user_wdata_i (user_wdata_i),
        .user_we_i    (user_we_i),
        .user_rdata_o (user_rdata_o)
    );

    bridge_tx u_bridge_tx (
        .clk         (clk),
        .rst_i       (rst_i),
        .rsp_data_i  (rsp_data),
        .rsp_valid_i (rsp_valid),
        .tx_done_i   (tx_done),
        .tx_byte_o   (tx_byte),
        .tx_start_o  (tx_start)
    );

    uart_tx #(
        .CLOCKS_PER_BAUD(CLOCKS_PER_BAUD)
    ) u_uart_tx (
        .clk        (clk),
        .rst_i      (rst_i),
        .tx_byte_i  (tx_byte),
        .tx_start_i (tx_start),
        .tx_done_o  (tx_done),
        .tx_o       (tx_o)
    );

endmodule

`default_nettype wire

/* debug_pkg.sv */
`default_nettype none

package debug_pkg;

    typedef logic [7:0]  byte_t;
    typedef logic [15:0] bus_addr_t;
    typedef logic [15:0] bus_data_t;

    // every ram bank holds one bus word
    localparam int BANK_WIDTH = 16;

    localparam byte_t CHAR_R  = 8'h52;
    localparam byte_t CHAR_W  = 8'h57;
    localparam byte_t CHAR_D  = 8'h44;
    localparam byte_t CHAR_CR = 8'h0D;
    localparam byte_t CHAR_LF = 8'h0A;

    typedef enum logic [1:0] {
        PARSE_IDLE,
        PARSE_READ,
        PARSE_WRITE
    } parse_state_e;

    // only upper-case digits are accepted
    function automatic logic is_hex_char(byte_t c);
        return ((c >= 8'h30) && (c <= 8'h39)) || ((c >= 8'h41) && (c <= 8'h46));
    endfunction

    function automatic logic [3:0] hex_to_nibble(byte_t c);
        byte_t v;
        v = (c <= 8'h39) ? (c - 8'h30) : (c - 8'h37);
        return v[3:0];
    endfunction

    function automatic byte_t nibble_to_hex(logic [3:0] n);
        return (n < 4'd10) ? (8'h30 + {4'h0, n}) : (8'h37 + {4'h0, n});
    endfunction

endpackage

`default_nettype wire

/* dual_port_ram.sv */
`default_nettype none

module dual_port_ram
    import debug_pkg::*;
#(
    parameter int MEM_DEPTH = 256
) (
    input  wire                         clk,
    input  wire [$clog2(MEM_DEPTH)-1:0] a_addr_i,
    input  wire [BANK_WIDTH-1:0]        a_wdata_i,
    input  wire                         a_we_i,
    output logic [BANK_WIDTH-1:0]       a_rdata_o,
    input  wire [$clog2(MEM_DEPTH)-1:0] b_addr_i,
    input  wire [BANK_WIDTH-1:0]        b_wdata_i,
    input  wire                         b_we_i,
    output logic [BANK_WIDTH-1:0]       b_rdata_o
);

    logic [BANK_WIDTH-1:0] mem [MEM_DEPTH];
    logic [BANK_WIDTH-1:0] a_read_q;
    logic [BANK_WIDTH-1:0] b_read_q;

    initial begin
        for (int i = 0; i < MEM_DEPTH; i++) begin
            mem[i] = '0;
        end
    end

    // read-first on both ports, port b wins a write collision
    always_ff @(posedge clk) begin
        if (a_we_i) begin
            mem[a_addr_i] <= a_wdata_i;
        end
        if (b_we_i) begin
            mem[b_addr_i] <= b_wdata_i;
        end
        a_read_q  <= mem[a_addr_i];
        b_read_q  <= mem[b_addr_i];
        a_rdata_o <= a_read_q;
        b_rdata_o <= b_read_q;
    end

endmodule

`default_nettype wire

/* list.f */
debug_pkg.sv
uart_rx.sv
uart_tx.sv
bridge_rx.sv
bridge_tx.sv
dual_port_ram.sv
block_memory.sv
debug_core.sv
tb_debug_core.sv

/* tb_debug_core.sv */
`default_nettype none

module tb_debug_core;

    localparam int CLOCKS_PER_BAUD = 8;
    localparam int MEM_WIDTH       = 32;
    localparam int MEM_DEPTH       = 256;
    localparam int ADDR_W          = $clog2(MEM_DEPTH);
    localparam int MAPPED_WORDS    = MEM_DEPTH * ((MEM_WIDTH + 15) / 16);
    localparam int CLK_PERIOD      = 100;
    localparam int DRIVE_DELAY     = 10;
    localparam int N_PAIRS         = 8;
    localparam logic [7:0] CR = 8'h0D;
    localparam logic [7:0] LF = 8'h0A;

    // run length counted in byte-times on the serial line
    localparam int WR_BYTES    = 10;
    localparam int RD_BYTES    = 6;
    localparam int REPLY_BYTES = 7;
    localparam int BYTE_CYCLES = 10 * CLOCKS_PER_BAUD;
    localparam int IDLE_BYTES  = 8;
    localparam int SWEEP_BYTES = (4 * MEM_DEPTH) / BYTE_CYCLES + 1;
    localparam int TOTAL_BYTES = IDLE_BYTES
        + N_PAIRS * (WR_BYTES + RD_BYTES + REPLY_BYTES)
        + 2 * (RD_BYTES + REPLY_BYTES)
        + 2 * WR_BYTES + RD_BYTES + REPLY_BYTES
        + 4 * WR_BYTES + RD_BYTES + 4 * REPLY_BYTES + RD_BYTES + REPLY_BYTES
        + 2 * WR_BYTES + 4 * (RD_BYTES + REPLY_BYTES) + SWEEP_BYTES;
    localparam int TIMEOUT_CYCLES = TOTAL_BYTES * BYTE_CYCLES * 2;
    localparam int REPLY_WAIT     = 2 * REPLY_BYTES * BYTE_CYCLES;
    localparam int SILENT_WAIT    = REPLY_BYTES * BYTE_CYCLES;

    logic                 clk;
    logic                 rst_i;
    logic                 rx_i;
    logic                 tx_o;
    logic [ADDR_W-1:0]    user_addr_i;
    logic [MEM_WIDTH-1:0] user_wdata_i;
    logic                 user_we_i;
    logic [MEM_WIDTH-1:0] user_rdata_o;

    // memory model with one entry per bus word
    logic [15:0] ref_mem [int];
    logic [7:0]  reply_q [$];
    int          value_errors;
    int          other_errors;
    int          check_count;
    int          cycle_count;

    debug_core #(
        .CLOCKS_PER_BAUD(CLOCKS_PER_BAUD),
        .MEM_WIDTH      (MEM_WIDTH),
        .MEM_DEPTH      (MEM_DEPTH)
    ) UUT (
        .clk          (clk),
        .rst_i        (rst_i),
        .rx_i         (rx_i),
        .tx_o         (tx_o),
        .user_addr_i  (user_addr_i),
        .user_wdata_i (user_wdata_i),
        .user_we_i    (user_we_i),
        .user_rdata_o (user_rdata_o)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic print_counts();
        $display("checks: %0d, value mismatches: %0d, other failures: %0d",
                 check_count, value_errors, other_errors);
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        check_count++;
        assert (actual === expected) else begin
            value_errors++;
            $display("FAILED time %0t: %s expected %h actual %h",
                     $time, name, expected, actual);
        end
    endtask

    function automatic string hex4(input logic [15:0] v);
        string s;
        s = $sformatf("%04h", v);
        return s.toupper();
    endfunction

    // unmapped addresses read as zero and drop writes
    function automatic logic [15:0] ref_read(input int addr);
        if ((addr < MAPPED_WORDS) && ref_mem.exists(addr)) begin
            return ref_mem[addr];
        end
        return 16'h0000;
    endfunction

    function automatic void ref_write(input int addr, input logic [15:0] data);
        if (addr < MAPPED_WORDS) begin
            ref_mem[addr] = data;
        end
    endfunction

    // entered a drive delay past a rising edge and left the same way
    task automatic drive_bit(input logic v);
        rx_i = v;
        repeat (CLOCKS_PER_BAUD) @(posedge clk);
        #DRIVE_DELAY;
    endtask

    task automatic send_byte(input logic [7:0] b);
        int i;
        drive_bit(1'b0);
        for (i = 0; i < 8; i++) begin
            drive_bit(b[i]);
        end
        drive_bit(1'b1);
    endtask

    task automatic send_text(input string s, input logic [7:0] term);
        int i;
        @(posedge clk);
        #DRIVE_DELAY;
        for (i = 0; i < s.len(); i++) begin
            send_byte(s[i]);
        end
        send_byte(term);
    endtask

    // host side receiver that samples near the middle of each bit
    task automatic receive_byte();
        logic [7:0] b;
        int         i;
        @(negedge clk);
        while (tx_o !== 1'b0) @(negedge clk);
        repeat (CLOCKS_PER_BAUD / 2 - 1) @(negedge clk);
        for (i = 0; i < 8; i++) begin
            repeat (CLOCKS_PER_BAUD) @(negedge clk);
            b[i] = tx_o;
        end
        repeat (CLOCKS_PER_BAUD) @(negedge clk);
        assert (tx_o === 1'b1) else begin
            other_errors++;
            $display("stop bit missing on tx_o at time %0t", $time);
        end
        reply_q.push_back(b);
    endtask

    initial begin
        @(negedge rst_i);
        forever begin
            receive_byte();
        end
    end

    task automatic expect_reply(input logic [15:0] word);
        string exp_text;
        int    waited;
        int    i;
        exp_text = {"D", hex4(word)};
        waited = 0;
        while ((reply_q.size() < REPLY_BYTES) && (waited < REPLY_WAIT)) begin
            @(posedge clk);
            waited++;
        end
        assert (reply_q.size() >= REPLY_BYTES) else begin
            other_errors++;
            $display("no complete reply to a read within %0d cycles, expected D%s",
                     waited, hex4(word));
        end
        if (reply_q.size() >= REPLY_BYTES) begin
            for (i = 0; i < 5; i++) begin
                check_value($sformatf("tx_o reply byte %0d", i), exp_text[i], reply_q[i]);
            end
            check_value("tx_o reply byte 5", CR, reply_q[5]);
            check_value("tx_o reply byte 6", LF, reply_q[6]);
        end
        reply_q.delete();
    endtask

    task automatic expect_silence(input string what, input int cycles);
        repeat (cycles) @(posedge clk);
        assert (reply_q.size() == 0) else begin
            other_errors++;
            $display("unexpected reply of %0d bytes after %s", reply_q.size(), what);
        end
        reply_q.delete();
    endtask

    task automatic uart_write(input logic [15:0] addr, input logic [15:0] data,
                              input logic [7:0] term);
        send_text({"W", hex4(addr), hex4(data)}, term);
        ref_write(addr, data);
    endtask

    task automatic read_check(input logic [15:0] addr, input logic [7:0] term);
        send_text({"R", hex4(addr)}, term);
        expect_reply(ref_read(addr));
    endtask

    // user word k holds bus words 2k (low half) and 2k+1 (high half)
    task automatic user_write(input int k, input logic [MEM_WIDTH-1:0] data);
        @(posedge clk);
        #DRIVE_DELAY;
        user_addr_i  = ADDR_W'(k);
        user_wdata_i = data;
        user_we_i    = 1'b1;
        @(posedge clk);
        #DRIVE_DELAY;
        user_we_i = 1'b0;
        ref_write(2 * k, data[15:0]);
        ref_write(2 * k + 1, data[31:16]);
    endtask

    task automatic user_read_check(input int k);
        @(posedge clk);
        #DRIVE_DELAY;
        user_addr_i = ADDR_W'(k);
        repeat (2) @(posedge clk);
        @(negedge clk);
        check_value($sformatf("user_rdata_o word %0d", k),
                    {ref_read(2 * k + 1), ref_read(2 * k)}, user_rdata_o);
    endtask

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        other_errors++;
        $display("run did not finish within %0d cycles", TIMEOUT_CYCLES);
        print_counts();
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin
        logic [15:0] addr;
        logic [31:0] word;
        int          seed;
        int          k;
        int          n;
        seed         = $urandom(32'h6d40);
        value_errors = 0;
        other_errors = 0;
        check_count  = 0;
        rst_i        = 1'b1;
        rx_i         = 1'b1;
        user_addr_i  = '0;
        user_wdata_i = '0;
        user_we_i    = 1'b0;
        repeat (10) @(posedge clk);
        #DRIVE_DELAY;
        rst_i = 1'b0;

        // quiet line after reset
        for (n = 0; n < IDLE_BYTES * BYTE_CYCLES; n++) begin
            @(negedge clk);
            check_value("tx_o", 32'h1, {31'b0, tx_o});
        end

        // write then read back with alternating terminators
        for (n = 0; n < N_PAIRS; n++) begin
            addr = 16'($urandom % MAPPED_WORDS);
            uart_write(addr, 16'($urandom), (n % 2 == 0) ? CR : LF);
            read_check(addr, (n % 2 == 0) ? LF : CR);
        end

        // user port write seen from the bus
        k    = $urandom % MEM_DEPTH;
        word = $urandom;
        user_write(k, word);
        read_check(16'(2 * k), CR);
        read_check(16'(2 * k + 1), LF);

        // bus writes seen from the user port
        k = $urandom % MEM_DEPTH;
        uart_write(16'(2 * k), 16'($urandom), LF);
        uart_write(16'(2 * k + 1), 16'($urandom), CR);
        read_check(16'(2 * k + 1), LF);
        user_read_check(k);

        // malformed commands aimed at a known word
        uart_write(16'h01A0, 16'h5A5A, CR);
        send_text("W01a0BEEF", CR);
        expect_silence("lower-case hex digit", SILENT_WAIT);
        send_text("W01A012Z4", LF);
        expect_silence("non-hex character", SILENT_WAIT);
        send_text("W01A0C0DE", "X");
        expect_silence("bad write terminator", SILENT_WAIT);
        send_text("R01A0", "X");
        expect_silence("bad read terminator", SILENT_WAIT);
        read_check(16'h01A0, LF);

        // last mapped word and then the unmapped range
        uart_write(16'h01FF, 16'($urandom), LF);
        read_check(16'h01FF, CR);
        // 0x0200 would alias word 0 of bank 0 without the range check
        uart_write(16'h0200, 16'hFFFF, CR);
        read_check(16'h0200, LF);
        read_check(16'hFFFF, CR);
        read_check(16'h0000, LF);
        for (k = 0; k < MEM_DEPTH; k++) begin
            user_read_check(k);
        end

        print_counts();
        if ((value_errors == 0) && (other_errors == 0)) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* uart_rx.sv */
`default_nettype none

module uart_rx
    import debug_pkg::*;
#(
    parameter int CLOCKS_PER_BAUD = 8
) (
    input  wire   clk,
    input  wire   rst_i,
    input  wire   rx_i,
    output byte_t rx_byte_o,
    output logic  rx_valid_o
);

    localparam int CNT_W = $clog2(2 * CLOCKS_PER_BAUD);
    localparam logic [3:0] BIT_IDLE = 4'd0;
    localparam logic [3:0] BIT_STOP = 4'd9;

    logic             rx_meta;
    logic             rx_sync;
    logic [3:0]       bit_idx;
    logic [CNT_W-1:0] baud_cnt;

    // two-flop synchronizer, line idles high
    always_ff @(posedge clk) begin
        if (rst_i) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
        end else begin
            rx_meta <= rx_i;
            rx_sync <= rx_meta;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            bit_idx    <= BIT_IDLE;
            baud_cnt   <= '0;
            rx_valid_o <= 1'b0;
        end else begin
            rx_valid_o <= 1'b0;
            if (bit_idx == BIT_IDLE) begin
                if (!rx_sync) begin
                    // skip the start bit and land mid-way into data bit 0
                    bit_idx  <= 4'd1;
                    baud_cnt <= CNT_W'(CLOCKS_PER_BAUD + CLOCKS_PER_BAUD / 2 - 1);
                end
            end else if (baud_cnt == '0) begin
                baud_cnt <= CNT_W'(CLOCKS_PER_BAUD - 1);
                if (bit_idx == BIT_STOP) begin
                    bit_idx    <= BIT_IDLE;
                    rx_valid_o <= 1'b1;
                end else begin
                    bit_idx <= bit_idx + 4'd1;
                end
            end else begin
                baud_cnt <= baud_cnt - 1'b1;
            end
        end
    end

    // data bits arrive lsb first
    always_ff @(posedge clk) begin
        if ((bit_idx != BIT_IDLE) && (bit_idx != BIT_STOP) && (baud_cnt == '0)) begin
            rx_byte_o <= {rx_sync, rx_byte_o[7:1]};
        end
    end

endmodule

`default_nettype wire

/* uart_tx.sv */
`default_nettype none

module uart_tx
    import debug_pkg::*;
#(
    parameter int CLOCKS_PER_BAUD = 8
) (
    input  wire        clk,
    input  wire        rst_i,
    input  wire byte_t tx_byte_i,
    input  wire        tx_start_i,
    output logic       tx_done_o,
    output logic       tx_o
);

    localparam int CNT_W = $clog2(CLOCKS_PER_BAUD + 1);
    localparam logic [3:0] BIT_LAST_DATA = 4'd8;
    localparam logic [3:0] BIT_STOP      = 4'd9;

    logic [CNT_W-1:0] baud_cnt;
    logic [3:0]       bit_idx;
    byte_t            shift_q;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            baud_cnt  <= '0;
            bit_idx   <= '0;
            tx_done_o <= 1'b1;
            tx_o      <= 1'b1;
        end else if (tx_start_i && tx_done_o) begin
            // start bit goes out now, either from idle or straight after a stop bit
            baud_cnt  <= CNT_W'(CLOCKS_PER_BAUD - 1);
            bit_idx   <= '0;
            tx_done_o <= 1'b0;
            tx_o      <= 1'b0;
        end else if (!tx_done_o) begin
            // done is high during the last clock of the stop bit
            tx_done_o <= (bit_idx == BIT_STOP) && (baud_cnt == CNT_W'(1));
            if (baud_cnt == '0) begin
                baud_cnt <= CNT_W'(CLOCKS_PER_BAUD - 1);
                bit_idx  <= bit_idx + 4'd1;
                if (bit_idx == BIT_LAST_DATA) begin
                    tx_o <= 1'b1;
                end else begin
                    tx_o <= shift_q[0];
                end
            end else begin
                baud_cnt <= baud_cnt - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (tx_start_i && tx_done_o) begin
            shift_q <= tx_byte_i;
        end else if (!tx_done_o && (baud_cnt == '0)) begin
            shift_q <= {1'b0, shift_q[7:1]};
        end
    end

endmodule

`default_nettype wire
